// File: rtl/mpls_ingress_pkg.sv
/* MPLS ingress shared definitions
   Converged bus widths, port map, buffer sizing and beat structs */

package mpls_ingress_pkg;

  //////////////////////////////
  // Converged bus and port map
  //////////////////////////////

  // Bytes per converged word
  localparam int CONV_BYTES = 8;

  // Physical port groups
  localparam int NUM_8B_PORTS = 2;
  localparam int NUM_32B_PORTS = 2;
  localparam int PORT_8B_BYTES = 1;
  localparam int PORT_32B_BYTES = 4;
  localparam int NUM_PORTS = NUM_8B_PORTS + NUM_32B_PORTS;
  localparam int PORT_IDX_W = 2;

  // Global index of first port in each group
  localparam int PORT_BASE_8B = 0;
  localparam int PORT_BASE_32B = PORT_BASE_8B + NUM_8B_PORTS;

  // Words per port buffer
  localparam int BUF_DEPTH = 16;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [CONV_BYTES*8-1:0] word_t;
  typedef logic [CONV_BYTES-1:0] keep_t;
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // Byte lane position inside a converged word
  typedef logic [$clog2(CONV_BYTES)-1:0] lane_t;

  // Buffer pointer, extra msb for wrap
  typedef logic [$clog2(BUF_DEPTH):0] buf_ptr_t;

  // One buffered word
  typedef struct packed {
    word_t data;
    keep_t keep;
    logic  last;
  } ing_beat_t;

  // One word on the converged bus, tagged with source port
  typedef struct packed {
    word_t     data;
    keep_t     keep;
    logic      last;
    port_idx_t port;
  } conv_beat_t;

endpackage

// File: rtl/mpls_ingress_width_adapt.sv
/* Width adapter for one ingress port
   Packs narrow input beats into 64-bit words with byte keep */

`timescale 1ns/1ps
`default_nettype none

module mpls_ingress_width_adapt
  import mpls_ingress_pkg::*;
#(
  parameter int IN_BYTES = 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic [IN_BYTES*8-1:0] in_data,
  input  logic [IN_BYTES-1:0]   in_keep,
  input  logic                  in_last,
  output logic                  wr_valid,
  output ing_beat_t             wr_beat
);

  // Next free lane in the gathering word
  lane_t lane;

  // Partially filled word
  word_t gather_data;
  keep_t gather_keep;

  // Word as it would look with the current beat merged in
  word_t next_data;
  keep_t next_keep;
  logic  emit;

  //////////////////////////////
  // Lane merge
  //////////////////////////////

  always_comb begin
    // Fresh word starts from zero so unfilled lanes read as zero
    next_data = (lane == '0) ? '0 : gather_data;
    next_keep = (lane == '0) ? '0 : gather_keep;
    for (int b = 0; b < IN_BYTES; b++) begin
      // Bytes outside keep stay zero
      if (in_keep[b]) begin
        next_data[(lane + b)*8 +: 8] = in_data[b*8 +: 8];
      end
    end
    next_keep[lane +: IN_BYTES] = in_keep;
  end

  // Word complete on last lane or end of packet
  assign emit = in_valid && (in_last || (lane == lane_t'(CONV_BYTES - IN_BYTES)));

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      lane     <= '0;
      wr_valid <= 1'b0;
    end else begin
      // One-cycle strobe, one cycle after the completing beat
      wr_valid <= emit;
      if (in_valid) begin
        lane <= emit ? '0 : lane + lane_t'(IN_BYTES);
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (in_valid) begin
      gather_data <= next_data;
      gather_keep <= next_keep;
    end
    if (emit) begin
      wr_beat.data <= next_data;
      wr_beat.keep <= next_keep;
      wr_beat.last <= in_last;
    end
  end

  // Input keep must be low-aligned and contiguous
  assert property (@(posedge clk) disable iff (rst)
    in_valid |-> (in_keep != '0) && ((in_keep & (in_keep + 1'b1)) == '0));

endmodule

`default_nettype wire

// File: rtl/mpls_ingress_port_buf.sv
/* Per-port packet buffer
   Words become readable once their packet is committed; overflow drops the packet */

`timescale 1ns/1ps
`default_nettype none

module mpls_ingress_port_buf
  import mpls_ingress_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_valid,
  input  ing_beat_t wr_beat,
  input  logic      rd_ready,
  output logic      rd_valid,
  output ing_beat_t rd_beat,
  output logic      overflow
);

  // Packet storage
  ing_beat_t mem [BUF_DEPTH];

  // Write head, end of last complete packet, read head
  buf_ptr_t wr_ptr;
  buf_ptr_t commit_ptr;
  buf_ptr_t rd_ptr;

  buf_ptr_t fill;
  logic     full;

  // Set after overflow until the packet's last word
  logic dropping;

  logic wr_take;
  logic wr_hit_full;

  //////////////////////////////
  // Status
  //////////////////////////////

  // Occupancy counts uncommitted words too
  assign fill = wr_ptr - rd_ptr;
  assign full = (fill == buf_ptr_t'(BUF_DEPTH));

  // Normal write
  assign wr_take = wr_valid && !dropping && !full;

  // Overflow hit, rewind
  assign wr_hit_full = wr_valid && !dropping && full;

  // Only committed words are visible
  assign rd_valid = (rd_ptr != commit_ptr);
  assign rd_beat  = mem[rd_ptr[$clog2(BUF_DEPTH)-1:0]];

  //////////////////////////////
  // Pointers and drop state
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      rd_ptr     <= '0;
      dropping   <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      // Single pulse per dropped packet
      overflow <= wr_hit_full;

      if (wr_take) begin
        wr_ptr <= wr_ptr + 1'b1;
        // Last word makes the whole packet readable next cycle
        if (wr_beat.last) begin
          commit_ptr <= wr_ptr + 1'b1;
        end
      end else if (wr_hit_full) begin
        // Discard the partial packet
        wr_ptr <= commit_ptr;
      end

      // Enter on overflow, leave on last
      if (wr_valid && (dropping || full)) begin
        dropping <= !wr_beat.last;
      end

      if (rd_valid && rd_ready) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (wr_take) begin
      mem[wr_ptr[$clog2(BUF_DEPTH)-1:0]] <= wr_beat;
    end
  end

  // Read side holds its word while stalled
  assert property (@(posedge clk) disable iff (rst)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_beat));

endmodule

`default_nettype wire

// File: rtl/mpls_ingress_port_array.sv
/* One width group of ingress ports
   Each port is a width adapter feeding its own packet buffer */

`timescale 1ns/1ps
`default_nettype none

module mpls_ingress_port_array
  import mpls_ingress_pkg::*;
#(
  parameter int NUM_GROUP_PORTS = 2,
  parameter int IN_BYTES = 1
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic      [NUM_GROUP_PORTS-1:0]                 in_valid,
  input  logic      [NUM_GROUP_PORTS-1:0][IN_BYTES*8-1:0] in_data,
  input  logic      [NUM_GROUP_PORTS-1:0][IN_BYTES-1:0]   in_keep,
  input  logic      [NUM_GROUP_PORTS-1:0]                 in_last,
  input  logic      [NUM_GROUP_PORTS-1:0]                 rd_ready,
  output logic      [NUM_GROUP_PORTS-1:0]                 rd_valid,
  output ing_beat_t [NUM_GROUP_PORTS-1:0]                 rd_beat,
  output logic      [NUM_GROUP_PORTS-1:0]                 overflow
);

  // Adapter and buffer kept together per port
  for (genvar p = 0; p < NUM_GROUP_PORTS; p++) begin : g_port
    logic      wr_valid;
    ing_beat_t wr_beat;

    mpls_ingress_width_adapt #(
      .IN_BYTES (IN_BYTES)
    ) i_adapt (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid[p]),
      .in_data  (in_data[p]),
      .in_keep  (in_keep[p]),
      .in_last  (in_last[p]),
      .wr_valid (wr_valid),
      .wr_beat  (wr_beat)
    );

    mpls_ingress_port_buf i_buf (
      .clk      (clk),
      .rst      (rst),
      .wr_valid (wr_valid),
      .wr_beat  (wr_beat),
      .rd_ready (rd_ready[p]),
      .rd_valid (rd_valid[p]),
      .rd_beat  (rd_beat[p]),
      .overflow (overflow[p])
    );
  end

endmodule

`default_nettype wire

// File: rtl/mpls_ingress_sched.sv
/* Round-robin packet scheduler
   Merges port buffers onto the converged bus and tags each word with its port */

`timescale 1ns/1ps
`default_nettype none

module mpls_ingress_sched
  import mpls_ingress_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic      [NUM_PORTS-1:0]       rd_valid,
  input  ing_beat_t [NUM_PORTS-1:0]       rd_beat,
  output logic      [NUM_PORTS-1:0]       rd_ready,
  output logic                            out_valid,
  output conv_beat_t                      out_beat,
  input  logic                            out_ready
);

  typedef enum logic {
    IDLE,
    SEND
  } state_t;

  state_t state;

  // Registered grant held for a whole packet
  logic [NUM_PORTS-1:0] grant;
  port_idx_t            grant_idx;

  // Last port served
  port_idx_t rr_ptr;

  port_idx_t pick_idx;
  logic      pick_found;
  logic      pkt_done;

  //////////////////////////////
  // Round-robin search
  //////////////////////////////

  always_comb begin : pick_search
    port_idx_t cand;
    pick_found = 1'b0;
    pick_idx   = rr_ptr;
    // Start one past the last served port
    for (int i = 1; i <= NUM_PORTS; i++) begin
      cand = port_idx_t'((int'(rr_ptr) + i) % NUM_PORTS);
      if (!pick_found && rd_valid[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  //////////////////////////////
  // Output mux
  //////////////////////////////

  assign out_valid = (state == SEND) && |(rd_valid & grant);

  // Only the granted buffer sees ready
  assign rd_ready = grant & {NUM_PORTS{out_ready && (state == SEND)}};

  always_comb begin
    out_beat.data = rd_beat[grant_idx].data;
    out_beat.keep = rd_beat[grant_idx].keep;
    out_beat.last = rd_beat[grant_idx].last;
    // Source tag
    out_beat.port = grant_idx;
  end

  assign pkt_done = out_valid && out_ready && out_beat.last;

  //////////////////////////////
  // Grant FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      grant     <= '0;
      grant_idx <= '0;
      // First search after reset lands on port 0
      rr_ptr    <= port_idx_t'(NUM_PORTS - 1);
    end else begin
      case (state)
        IDLE: begin
          if (pick_found) begin
            state     <= SEND;
            grant     <= {{(NUM_PORTS-1){1'b0}}, 1'b1} << pick_idx;
            grant_idx <= pick_idx;
          end
        end
        SEND: begin
          // Release only after last word accepted
          if (pkt_done) begin
            state  <= IDLE;
            grant  <= '0;
            rr_ptr <= grant_idx;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Exactly one port owns the bus while sending and its packet never runs dry
  assert property (@(posedge clk) disable iff (rst)
    state == SEND |-> $onehot(grant) && rd_valid[grant_idx]);

  // Stalled output word stays put through buffer and mux
  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

`default_nettype wire

// File: rtl/mpls_ingress.sv
/* MPLS router ingress top
   8-bit and 32-bit port groups merged onto one 64-bit converged bus */

`timescale 1ns/1ps
`default_nettype none

module mpls_ingress
  import mpls_ingress_pkg::*;
(
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [NUM_8B_PORTS-1:0]                          in8_valid,
  input  logic [NUM_8B_PORTS-1:0][PORT_8B_BYTES*8-1:0]     in8_data,
  input  logic [NUM_8B_PORTS-1:0][PORT_8B_BYTES-1:0]       in8_keep,
  input  logic [NUM_8B_PORTS-1:0]                          in8_last,
  input  logic [NUM_32B_PORTS-1:0]                         in32_valid,
  input  logic [NUM_32B_PORTS-1:0][PORT_32B_BYTES*8-1:0]   in32_data,
  input  logic [NUM_32B_PORTS-1:0][PORT_32B_BYTES-1:0]     in32_keep,
  input  logic [NUM_32B_PORTS-1:0]                         in32_last,
  input  logic                                             out_ready,
  output logic                                             out_valid,
  output conv_beat_t                                       out_beat,
  output logic [NUM_8B_PORTS-1:0]                          ing_8b_overflow,
  output logic [NUM_32B_PORTS-1:0]                         ing_32b_overflow
);

  // Buffer outputs in global port order
  logic      [NUM_PORTS-1:0] buf_valid;
  logic      [NUM_PORTS-1:0] buf_ready;
  ing_beat_t [NUM_PORTS-1:0] buf_beat;

  //////////////////////////////
  // Port groups
  //////////////////////////////

  // 8-bit ports
  mpls_ingress_port_array #(
    .NUM_GROUP_PORTS (NUM_8B_PORTS),
    .IN_BYTES        (PORT_8B_BYTES)
  ) i_array_8b (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in8_valid),
    .in_data  (in8_data),
    .in_keep  (in8_keep),
    .in_last  (in8_last),
    .rd_ready (buf_ready[PORT_BASE_8B +: NUM_8B_PORTS]),
    .rd_valid (buf_valid[PORT_BASE_8B +: NUM_8B_PORTS]),
    .rd_beat  (buf_beat[PORT_BASE_8B +: NUM_8B_PORTS]),
    .overflow (ing_8b_overflow)
  );

  // 32-bit ports
  mpls_ingress_port_array #(
    .NUM_GROUP_PORTS (NUM_32B_PORTS),
    .IN_BYTES        (PORT_32B_BYTES)
  ) i_array_32b (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in32_valid),
    .in_data  (in32_data),
    .in_keep  (in32_keep),
    .in_last  (in32_last),
    .rd_ready (buf_ready[PORT_BASE_32B +: NUM_32B_PORTS]),
    .rd_valid (buf_valid[PORT_BASE_32B +: NUM_32B_PORTS]),
    .rd_beat  (buf_beat[PORT_BASE_32B +: NUM_32B_PORTS]),
    .overflow (ing_32b_overflow)
  );

  //////////////////////////////
  // Merge to converged bus
  //////////////////////////////

  mpls_ingress_sched i_sched (
    .clk       (clk),
    .rst       (rst),
    .rd_valid  (buf_valid),
    .rd_beat   (buf_beat),
    .rd_ready  (buf_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
/* Testbench clock and reset
   Free-running clock, reset held high for the first cycles */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lands on a falling edge, same as the other inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: tb/tb_mpls_ingress.sv
/* MPLS ingress testbench
   Drives all four ports, keeps per-port reference queues, checks with assertions */

`timescale 1ns/1ps

module tb_mpls_ingress
  import mpls_ingress_pkg::*;
();

  localparam int CLK_PERIOD_NS = 40;
  localparam int RESET_CYCLES = 10;

  // Packet mix
  localparam int RR_BYTES = 12;
  localparam int OVF_PORT = 3;
  localparam int OVF_BYTES = (BUF_DEPTH + 4) * CONV_BYTES;
  localparam int NUM_RAND = 16;
  localparam int MAX_RAND_BYTES = 24;

  // Upper bound on driven cycles, 8-bit beats being the slowest
  localparam int STIM_CYCLES = RESET_CYCLES + NUM_PORTS * (RR_BYTES + 2) +
    OVF_BYTES / PORT_32B_BYTES + RR_BYTES + NUM_RAND * MAX_RAND_BYTES + 16;
  localparam longint TIMEOUT_NS = 4 * STIM_CYCLES * CLK_PERIOD_NS;

  logic clk;
  logic rst;

  logic [NUM_8B_PORTS-1:0]                        in8_valid;
  logic [NUM_8B_PORTS-1:0][PORT_8B_BYTES*8-1:0]   in8_data;
  logic [NUM_8B_PORTS-1:0][PORT_8B_BYTES-1:0]     in8_keep;
  logic [NUM_8B_PORTS-1:0]                        in8_last;
  logic [NUM_32B_PORTS-1:0]                       in32_valid;
  logic [NUM_32B_PORTS-1:0][PORT_32B_BYTES*8-1:0] in32_data;
  logic [NUM_32B_PORTS-1:0][PORT_32B_BYTES-1:0]   in32_keep;
  logic [NUM_32B_PORTS-1:0]                       in32_last;
  logic                                           out_ready;
  logic                                           out_valid;
  conv_beat_t                                     out_beat;
  logic [NUM_8B_PORTS-1:0]                        ing_8b_overflow;
  logic [NUM_32B_PORTS-1:0]                       ing_32b_overflow;

  // Overflow bits in global port order
  logic [NUM_PORTS-1:0] ovf_all;

  // Reference model state
  ing_beat_t ref_q [NUM_PORTS][$];
  ing_beat_t head_beat [NUM_PORTS];
  logic [NUM_PORTS-1:0] head_ok;
  ing_beat_t exp_word;
  ing_beat_t out_word;
  conv_beat_t prev_beat;

  // Packet tracking on the output side
  logic      in_pkt;
  port_idx_t pkt_port;
  int        rr_count;
  logic [NUM_PORTS-1:0][7:0] ovf_count;
  logic [NUM_PORTS-1:0][7:0] ovf_exp;

  integer seed;
  logic   rand_ready;
  logic   rr_phase;
  logic   tests_done;

  tb_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  mpls_ingress i_dut (
    .clk              (clk),
    .rst              (rst),
    .in8_valid        (in8_valid),
    .in8_data         (in8_data),
    .in8_keep         (in8_keep),
    .in8_last         (in8_last),
    .in32_valid       (in32_valid),
    .in32_data        (in32_data),
    .in32_keep        (in32_keep),
    .in32_last        (in32_last),
    .out_ready        (out_ready),
    .out_valid        (out_valid),
    .out_beat         (out_beat),
    .ing_8b_overflow  (ing_8b_overflow),
    .ing_32b_overflow (ing_32b_overflow)
  );

  assign ovf_all  = {ing_32b_overflow, ing_8b_overflow};
  assign exp_word = head_beat[out_beat.port];
  assign out_word = {out_beat.data, out_beat.keep, out_beat.last};

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic void refresh_head(input int port);
    head_ok[port]   = (ref_q[port].size() != 0);
    head_beat[port] = head_ok[port] ? ref_q[port][0] : '0;
  endfunction

  // Bytes fill lanes from 0 up, a word closes at 8 bytes or at packet end
  function automatic void expect_words(input int port, input logic [7:0] pkt [$]);
    ing_beat_t w;
    int n;
    w = '0;
    n = 0;
    foreach (pkt[i]) begin
      w.data[n*8 +: 8] = pkt[i];
      w.keep[n] = 1'b1;
      n++;
      if (n == CONV_BYTES || i == pkt.size() - 1) begin
        w.last = (i == pkt.size() - 1);
        ref_q[port].push_back(w);
        w = '0;
        n = 0;
      end
    end
    refresh_head(port);
  endfunction

  // Advance to the next falling edge, then maybe toggle back-pressure
  task automatic next_cycle();
    @(negedge clk);
    if (rand_ready) begin
      out_ready = 1'($random(seed));
    end
  endtask

  task automatic send_packet(input int port, input int nbytes, input bit drop);
    logic [7:0] pkt [$];
    int step;
    int g;
    step = (port < PORT_BASE_32B) ? PORT_8B_BYTES : PORT_32B_BYTES;
    g = port - PORT_BASE_32B;
    for (int i = 0; i < nbytes; i++) begin
      pkt.push_back(8'($random(seed)));
    end
    // Dropped packets never reach the output
    if (drop) begin
      ovf_exp[port] = ovf_exp[port] + 1'b1;
    end else begin
      expect_words(port, pkt);
    end
    for (int b = 0; b < nbytes; b += step) begin
      if (port < PORT_BASE_32B) begin
        in8_valid[port] = 1'b1;
        in8_data[port]  = pkt[b];
        in8_keep[port]  = 1'b1;
        in8_last[port]  = (b + 1 >= nbytes);
      end else begin
        in32_valid[g] = 1'b1;
        in32_data[g]  = '0;
        in32_keep[g]  = '0;
        in32_last[g]  = (b + step >= nbytes);
        // Short tail beat, keep stays low-aligned
        for (int j = 0; j < step && b + j < nbytes; j++) begin
          in32_data[g][j*8 +: 8] = pkt[b + j];
          in32_keep[g][j] = 1'b1;
        end
      end
      next_cycle();
    end
    in8_valid  = '0;
    in32_valid = '0;
  endtask

  //////////////////////////////
  // Output tracking
  //////////////////////////////

  always @(posedge clk) begin : track_output
    int p;
    prev_beat <= out_beat;
    if (rst) begin
      in_pkt    <= 1'b0;
      pkt_port  <= '0;
      rr_count  <= 0;
      ovf_count <= '0;
    end else begin
      if (out_valid && out_ready) begin
        p = int'(out_beat.port);
        if (head_ok[p]) begin
          void'(ref_q[p].pop_front());
          refresh_head(p);
        end
        in_pkt   <= !out_beat.last;
        pkt_port <= out_beat.port;
        if (out_beat.last) begin
          rr_count <= rr_count + 1;
        end
      end
      // Counts high cycles, so a long pulse shows up too
      for (int q = 0; q < NUM_PORTS; q++) begin
        ovf_count[q] <= ovf_count[q] + ovf_all[q];
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge clk) $past(rst) |-> !out_valid && ovf_all == '0)
    else fail_run($sformatf("[FAIL] reset_state expected 0 actual %0h",
      $sampled({out_valid, ovf_all})));

  assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> head_ok[out_beat.port])
    else fail_run($sformatf("Output word on port %0d has no word left in its reference queue",
      $sampled(out_beat.port)));

  assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && head_ok[out_beat.port] |-> exp_word == out_word)
    else fail_run($sformatf("[FAIL] data_integrity expected %h actual %h",
      $sampled(exp_word), $sampled(out_word)));

  assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && in_pkt |-> out_beat.port == pkt_port)
    else fail_run($sformatf("[FAIL] no_interleave expected %0d actual %0d",
      $sampled(pkt_port), $sampled(out_beat.port)));

  // First word of each packet in the ordering phase
  assert property (@(posedge clk) disable iff (rst)
    rr_phase && out_valid && out_ready && !in_pkt |-> out_beat.port == port_idx_t'(rr_count))
    else fail_run($sformatf("[FAIL] round_robin expected %0d actual %0d",
      $sampled(port_idx_t'(rr_count)), $sampled(out_beat.port)));

  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && out_beat == prev_beat)
    else fail_run($sformatf("[FAIL] back_pressure expected 1 %h actual %0d %h",
      $sampled(prev_beat), $sampled(out_valid), $sampled(out_beat)));

  assert property (@(posedge clk) disable iff (rst)
    tests_done |-> head_ok == '0 && !out_valid)
    else fail_run("Reference queues not empty or output still valid at end of run");

  assert property (@(posedge clk) disable iff (rst)
    tests_done |-> ovf_count == ovf_exp)
    else fail_run($sformatf("[FAIL] overflow_drop expected %h actual %h",
      $sampled(ovf_exp), $sampled(ovf_count)));

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin : stimulus
    seed       = 32'h299e;
    in8_valid  = '0;
    in8_data   = '0;
    in8_keep   = '0;
    in8_last   = '0;
    in32_valid = '0;
    in32_data  = '0;
    in32_keep  = '0;
    in32_last  = '0;
    out_ready  = 1'b0;
    rand_ready = 1'b0;
    rr_phase   = 1'b0;
    tests_done = 1'b0;
    ovf_exp    = '0;
    head_ok    = '0;
    @(negedge rst);
    @(negedge clk);

    // One packet per port behind a stalled bus, port 0 commits first
    rr_phase = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      send_packet(p, RR_BYTES, 1'b0);
    end
    // Adapter write plus commit latency
    repeat (2) next_cycle();
    out_ready = 1'b1;
    while (rr_count < NUM_PORTS) next_cycle();
    rr_phase = 1'b0;

    // Oversized packet, then a normal one on the same port
    send_packet(OVF_PORT, OVF_BYTES, 1'b1);
    send_packet(OVF_PORT, RR_BYTES, 1'b0);

    // Short packets under random back-pressure
    rand_ready = 1'b1;
    for (int i = 0; i < NUM_RAND; i++) begin
      send_packet($unsigned($random(seed)) % NUM_PORTS,
        $unsigned($random(seed)) % MAX_RAND_BYTES + 1, 1'b0);
    end
    while (head_ok != '0) next_cycle();
    rand_ready = 1'b0;
    out_ready  = 1'b1;
    repeat (8) next_cycle();

    // End-of-run checks sample this
    tests_done = 1'b1;
    next_cycle();
    $display("sim passed");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    fail_run("Run timed out before all packets were delivered");
  end

endmodule

// File: mpls_ingress.f
rtl/mpls_ingress_pkg.sv
rtl/mpls_ingress_width_adapt.sv
rtl/mpls_ingress_port_buf.sv
rtl/mpls_ingress_port_array.sv
rtl/mpls_ingress_sched.sv
rtl/mpls_ingress.sv
tb/tb_clk_gen.sv
tb/tb_mpls_ingress.sv

// File: Bender.yml
package:
  name: mpls_ingress

sources:
  - rtl/mpls_ingress_pkg.sv
  - rtl/mpls_ingress_width_adapt.sv
  - rtl/mpls_ingress_port_buf.sv
  - rtl/mpls_ingress_port_array.sv
  - rtl/mpls_ingress_sched.sv
  - rtl/mpls_ingress.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_mpls_ingress.sv
